// ==== coh_dir.f ====
+incdir+dv
design/coh_dir_pkg.sv
design/coh_req_queue.sv
design/coh_dir_array.sv
design/coh_dir_ctrl.sv
design/coh_dir_stats.sv
design/coh_dir_top.sv
dv/coh_dir_tb.sv

// ==== design/coh_dir_array.sv ====
`timescale 1ns/1ps

module coh_dir_array (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic [coh_dir_pkg::addr_width-1:0] lookup_addr,
    input  coh_dir_pkg::dir_write_t            wr,
    input  logic                               wr_en,
    output coh_dir_pkg::dir_lookup_t           lookup
);
    import coh_dir_pkg::*;

    dir_entry_t            entry_q [num_entries];
    dir_entry_t            cur;
    logic [index_bits-1:0] idx;
    logic [tag_bits-1:0]   tag;
    logic                  tag_match;

    // Address split
    assign idx = lookup_addr[offset_bits +: index_bits];
    assign tag = lookup_addr[addr_width-1 -: tag_bits];

    assign cur       = entry_q[idx];
    assign tag_match = (cur.tag == tag);

    // Combinational lookup
    always_comb begin
        lookup.hit          = cur.valid && tag_match;
        lookup.victim_valid = cur.valid && !tag_match;
        lookup.entry        = cur;
    end

    // Whole-entry write, visible on the next cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < num_entries; i++) begin
                entry_q[i] <= '0;
            end
        end else if (wr_en) begin
            entry_q[wr.index] <= wr.entry;
        end
    end

endmodule

// ==== design/coh_dir_ctrl.sv ====
`timescale 1ns/1ps

module coh_dir_ctrl (
    input  logic                               clk,
    input  logic                               reset_n,
    input  coh_dir_pkg::dir_req_t              head,
    input  logic                               head_valid,
    output logic                               pop,
    output logic [coh_dir_pkg::addr_width-1:0] lookup_addr,
    input  coh_dir_pkg::dir_lookup_t           lookup,
    output coh_dir_pkg::dir_write_t            wr,
    output logic                               wr_en,
    input  logic                               ack_valid,
    input  coh_dir_pkg::node_id_t              ack_source,
    output coh_dir_pkg::noc_msg_t              msg,
    output logic                               msg_valid,
    input  logic                               msg_ready,
    output coh_dir_pkg::stat_event_t           stat
);
    import coh_dir_pkg::*;

    dir_state_t              state;
    dir_state_t              state_nxt;
    dir_req_t                req_q;
    dir_entry_t              new_entry_q;
    dir_entry_t              base;
    dir_entry_t              new_entry;
    core_mask_t              req_bit;
    core_mask_t              inv_targets;
    core_mask_t              inv_left;
    core_mask_t              ack_pend;
    logic [core_id_bits-1:0] req_core;
    logic [core_id_bits-1:0] inv_core;
    logic                    from_mc;
    logic                    msg_fire;

    // Lowest set core in a mask
    function automatic logic [core_id_bits-1:0] first_core(input core_mask_t m);
        logic [core_id_bits-1:0] id;
        id = '0;
        for (int i = num_cores - 1; i >= 0; i--) begin
            if (m[i]) begin
                id = core_id_bits'(i);
            end
        end
        return id;
    endfunction

    assign from_mc     = req_q.source[7];
    assign req_core    = req_q.source[core_id_bits-1:0];
    assign req_bit     = core_mask_t'(1) << req_core;
    assign inv_core    = first_core(inv_left);
    assign lookup_addr = req_q.addr;
    assign pop         = (state == IDLE) && head_valid;
    assign msg_fire    = msg_valid && msg_ready;

    // Protocol rules applied to the looked-up entry
    always_comb begin
        base = lookup.entry;
        if (!lookup.hit) begin
            // Miss starts a fresh entry with no sharers
            base       = '0;
            base.valid = 1'b1;
            base.tag   = req_q.addr[addr_width-1 -: tag_bits];
        end
        new_entry   = base;
        inv_targets = '0;
        unique case (req_q.op)
            REQ_READ: begin
                if (base.exclusive && base.owner != req_core) begin
                    inv_targets       = core_mask_t'(1) << base.owner;
                    new_entry.sharers = base.sharers & ~inv_targets;
                end
                new_entry.sharers   = new_entry.sharers | req_bit;
                new_entry.exclusive = 1'b0;
            end
            REQ_READ_EXCL, REQ_WRITE: begin
                inv_targets         = base.sharers & ~req_bit;
                new_entry.sharers   = req_bit;
                new_entry.owner     = req_core;
                new_entry.exclusive = 1'b1;
            end
            REQ_INVALIDATE: begin
                if (from_mc) begin
                    inv_targets         = base.sharers;
                    new_entry.sharers   = '0;
                    new_entry.valid     = 1'b0;
                    new_entry.exclusive = 1'b0;
                end else begin
                    new_entry.sharers = base.sharers & ~req_bit;
                    if (new_entry.sharers == '0) begin
                        new_entry.valid     = 1'b0;
                        new_entry.exclusive = 1'b0;
                    end
                end
            end
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:      if (head_valid) state_nxt = LOOKUP;
            LOOKUP:    state_nxt = SEND_INV;
            SEND_INV:  if (inv_left == '0) state_nxt = WAIT_ACKS;
            WAIT_ACKS: if (ack_pend == '0) state_nxt = UPDATE;
            UPDATE:    state_nxt = RESPOND;
            RESPOND:   if (msg_ready) state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= IDLE;
            inv_left <= '0;
            ack_pend <= '0;
        end else begin
            state <= state_nxt;
            if (state == LOOKUP) begin
                inv_left <= inv_targets;
                ack_pend <= inv_targets;
            end else begin
                if (state == SEND_INV && msg_fire) begin
                    inv_left[inv_core] <= 1'b0;
                end
                // Acks from the memory controller are not ours to count
                if (ack_valid && !ack_source[7]) begin
                    ack_pend[ack_source[core_id_bits-1:0]] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            req_q <= head;
        end
        if (state == LOOKUP) begin
            new_entry_q <= new_entry;
        end
    end

    assign wr_en    = (state == UPDATE);
    assign wr.index = req_q.addr[offset_bits +: index_bits];
    assign wr.entry = new_entry_q;

    assign stat.hit   = (state == LOOKUP) && lookup.hit;
    assign stat.miss  = (state == LOOKUP) && !lookup.hit;
    assign stat.evict = (state == LOOKUP) && lookup.victim_valid;

    // Outbound message, invalidations first then the reply
    assign msg_valid = ((state == SEND_INV) && (inv_left != '0)) || (state == RESPOND);

    always_comb begin
        msg.addr   = req_q.addr;
        msg.target = req_q.source;
        msg.op     = MSG_ACK;
        if (state == SEND_INV) begin
            msg.op     = MSG_INVALIDATE;
            msg.target = node_id_t'(inv_core);
        end else begin
            case (req_q.op)
                REQ_READ:      msg.op = MSG_DATA;
                REQ_READ_EXCL: msg.op = MSG_DATA_EXCL;
                default:       msg.op = MSG_ACK;
            endcase
        end
    end

    a_msg_hold: assert property (
        @(posedge clk) disable iff (!reset_n)
        msg_valid && !msg_ready |=> msg_valid && $stable(msg)
    );

    // Exclusive entries are held by the owner alone and invalid ones by nobody
    a_wr_entry_legal: assert property (
        @(posedge clk) disable iff (!reset_n)
        wr_en |-> (!wr.entry.exclusive ||
                   wr.entry.sharers == (core_mask_t'(1) << wr.entry.owner)) &&
                  (wr.entry.valid || (wr.entry.sharers == '0 && !wr.entry.exclusive))
    );

endmodule

// ==== design/coh_dir_pkg.sv ====
package coh_dir_pkg;

    // Geometry of the directory
    localparam int num_cores    = 4;
    localparam int core_id_bits = 2;
    localparam int addr_width   = 32;
    localparam int offset_bits  = 6;
    localparam int num_entries  = 16;
    localparam int index_bits   = 4;
    localparam int tag_bits     = addr_width - offset_bits - index_bits;
    localparam int queue_depth  = 4;

    // Stats register map
    localparam int stat_width = 32;
    localparam logic [addr_width-1:0] stat_hit_addr   = 32'h0000_0000;
    localparam logic [addr_width-1:0] stat_miss_addr  = 32'h0000_0004;
    localparam logic [addr_width-1:0] stat_evict_addr = 32'h0000_0008;

    // AXI response codes
    localparam logic [1:0] axi_resp_okay   = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    typedef logic [num_cores-1:0] core_mask_t;

    // Bit 7 set means the memory controller, bits 1:0 give the core
    typedef logic [7:0] node_id_t;

    typedef enum logic [1:0] {
        REQ_READ       = 2'd0,
        REQ_READ_EXCL  = 2'd1,
        REQ_WRITE      = 2'd2,
        REQ_INVALIDATE = 2'd3
    } req_op_t;

    typedef enum logic [1:0] {
        MSG_INVALIDATE = 2'd0,
        MSG_DATA       = 2'd1,
        MSG_DATA_EXCL  = 2'd2,
        MSG_ACK        = 2'd3
    } msg_op_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        req_op_t               op;
        node_id_t              source;
    } dir_req_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        msg_op_t               op;
        node_id_t              target;
    } noc_msg_t;

    typedef struct packed {
        logic                    valid;
        logic [tag_bits-1:0]     tag;
        core_mask_t              sharers;
        logic [core_id_bits-1:0] owner;
        logic                    exclusive;
    } dir_entry_t;

    typedef struct packed {
        logic       hit;
        logic       victim_valid;
        dir_entry_t entry;
    } dir_lookup_t;

    typedef struct packed {
        logic [index_bits-1:0] index;
        dir_entry_t            entry;
    } dir_write_t;

    typedef struct packed {
        logic hit;
        logic miss;
        logic evict;
    } stat_event_t;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        SEND_INV  = 3'd2,
        WAIT_ACKS = 3'd3,
        UPDATE    = 3'd4,
        RESPOND   = 3'd5
    } dir_state_t;

endpackage

// ==== design/coh_dir_stats.sv ====
`timescale 1ns/1ps

module coh_dir_stats (
    input  logic                               clk,
    input  logic                               reset_n,
    input  coh_dir_pkg::stat_event_t           stat,
    input  logic [coh_dir_pkg::addr_width-1:0] araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [coh_dir_pkg::stat_width-1:0] rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready
);
    import coh_dir_pkg::*;

    logic [stat_width-1:0] hit_cnt;
    logic [stat_width-1:0] miss_cnt;
    logic [stat_width-1:0] evict_cnt;
    logic [stat_width-1:0] rd_data;
    logic [1:0]            rd_resp;

    // Counters stop at all ones
    function automatic logic [stat_width-1:0] sat_inc(input logic [stat_width-1:0] v,
                                                      input logic en);
        if (en && v != '1) begin
            return v + 1'b1;
        end
        return v;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hit_cnt   <= '0;
            miss_cnt  <= '0;
            evict_cnt <= '0;
        end else begin
            hit_cnt   <= sat_inc(hit_cnt, stat.hit);
            miss_cnt  <= sat_inc(miss_cnt, stat.miss);
            evict_cnt <= sat_inc(evict_cnt, stat.evict);
        end
    end

    // Register select
    always_comb begin
        rd_data = '0;
        rd_resp = axi_resp_slverr;
        case (araddr)
            stat_hit_addr: begin
                rd_data = hit_cnt;
                rd_resp = axi_resp_okay;
            end
            stat_miss_addr: begin
                rd_data = miss_cnt;
                rd_resp = axi_resp_okay;
            end
            stat_evict_addr: begin
                rd_data = evict_cnt;
                rd_resp = axi_resp_okay;
            end
            default: begin
                rd_data = '0;
                rd_resp = axi_resp_slverr;
            end
        endcase
    end

    // One read in flight
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (arvalid && arready) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (rvalid && rready) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else if (!rvalid) begin
            arready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    a_r_hold: assert property (
        @(posedge clk) disable iff (!reset_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

// ==== design/coh_dir_top.sv ====
`timescale 1ns/1ps

module coh_dir_top (
    input  logic                               clk,
    input  logic                               reset_n,
    input  coh_dir_pkg::dir_req_t              req,
    input  logic                               req_valid,
    output logic                               req_ready,
    input  logic                               ack_valid,
    input  coh_dir_pkg::node_id_t              ack_source,
    output coh_dir_pkg::noc_msg_t              msg,
    output logic                               msg_valid,
    input  logic                               msg_ready,
    input  logic [coh_dir_pkg::addr_width-1:0] araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [coh_dir_pkg::stat_width-1:0] rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready
);
    import coh_dir_pkg::*;

    dir_req_t              head;
    logic                  head_valid;
    logic                  pop;
    logic [addr_width-1:0] lookup_addr;
    dir_lookup_t           lookup;
    dir_write_t            wr;
    logic                  wr_en;
    stat_event_t           stat;

    coh_req_queue u_req_queue (
        .clk        (clk),
        .reset_n    (reset_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid)
    );

    coh_dir_array u_dir_array (
        .clk         (clk),
        .reset_n     (reset_n),
        .lookup_addr (lookup_addr),
        .wr          (wr),
        .wr_en       (wr_en),
        .lookup      (lookup)
    );

    coh_dir_ctrl u_dir_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .head        (head),
        .head_valid  (head_valid),
        .pop         (pop),
        .lookup_addr (lookup_addr),
        .lookup      (lookup),
        .wr          (wr),
        .wr_en       (wr_en),
        .ack_valid   (ack_valid),
        .ack_source  (ack_source),
        .msg         (msg),
        .msg_valid   (msg_valid),
        .msg_ready   (msg_ready),
        .stat        (stat)
    );

    coh_dir_stats u_dir_stats (
        .clk     (clk),
        .reset_n (reset_n),
        .stat    (stat),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

// ==== design/coh_req_queue.sv ====
`timescale 1ns/1ps

module coh_req_queue (
    input  logic                 clk,
    input  logic                 reset_n,
    input  coh_dir_pkg::dir_req_t req,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  logic                 pop,
    output coh_dir_pkg::dir_req_t head,
    output logic                 head_valid
);
    import coh_dir_pkg::*;

    dir_req_t                     mem [queue_depth];
    logic [$clog2(queue_depth)-1:0] wr_ptr;
    logic [$clog2(queue_depth)-1:0] rd_ptr;
    logic [$clog2(queue_depth):0]   count;
    logic [$clog2(queue_depth):0]   count_nxt;
    logic                           push;

    assign push       = req_valid && req_ready;
    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    always_comb begin
        count_nxt = count;
        if (push && !pop) begin
            count_nxt = count + 1'b1;
        end else if (pop && !push) begin
            count_nxt = count - 1'b1;
        end
    end

    // Ready is registered so it stays low through reset
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            req_ready <= 1'b0;
        end else begin
            count     <= count_nxt;
            req_ready <= (count_nxt != queue_depth);
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req;
        end
    end

    // Controller must only take a request that is there
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!reset_n) pop |-> head_valid
    );

endmodule

// ==== dv/coh_dir_model.svh ====
`ifndef COH_DIR_MODEL_SVH
`define COH_DIR_MODEL_SVH

// Reference directory and the outbound messages expected, in send order
dir_entry_t ref_dir [num_entries];
noc_msg_t   exp_msgs [$];
int         exp_hits;
int         exp_misses;
int         exp_evicts;

task automatic clear_model();
    for (int i = 0; i < num_entries; i++) begin
        ref_dir[i] = '0;
    end
    exp_msgs.delete();
    exp_hits   = 0;
    exp_misses = 0;
    exp_evicts = 0;
endtask

// One accepted request, processed in acceptance order
task automatic apply_request(input dir_req_t r);
    logic [index_bits-1:0] idx;
    logic [tag_bits-1:0]   tag;
    logic [1:0]            core;
    logic                  from_mc;
    core_mask_t            s_bit;
    core_mask_t            inv;
    dir_entry_t            e;
    noc_msg_t              m;
    idx     = r.addr[offset_bits +: index_bits];
    tag     = r.addr[addr_width-1 -: tag_bits];
    core    = r.source[1:0];
    from_mc = r.source[7];
    s_bit   = 4'b0001 << core;
    inv     = '0;
    e       = ref_dir[idx];
    if (e.valid && e.tag == tag) begin
        exp_hits++;
    end else begin
        exp_misses++;
        if (e.valid) begin
            exp_evicts++;
        end
        e       = '0;
        e.valid = 1'b1;
        e.tag   = tag;
    end
    case (r.op)
        REQ_READ: begin
            // Another core holding the line exclusively loses it
            if (e.exclusive && e.owner != core) begin
                inv       = 4'b0001 << e.owner;
                e.sharers = e.sharers & ~inv;
            end
            e.sharers   = e.sharers | s_bit;
            e.exclusive = 1'b0;
        end
        REQ_READ_EXCL, REQ_WRITE: begin
            inv         = e.sharers & ~s_bit;
            e.sharers   = s_bit;
            e.owner     = core;
            e.exclusive = 1'b1;
        end
        default: begin
            if (from_mc) begin
                inv = e.sharers;
                e.sharers = '0;
            end else begin
                e.sharers = e.sharers & ~s_bit;
            end
            if (e.sharers == '0) begin
                e.valid     = 1'b0;
                e.exclusive = 1'b0;
            end
        end
    endcase
    for (int c = 0; c < num_cores; c++) begin
        if (inv[c]) begin
            m.addr   = r.addr;
            m.op     = MSG_INVALIDATE;
            m.target = node_id_t'(c);
            exp_msgs.push_back(m);
        end
    end
    m.addr   = r.addr;
    m.target = r.source;
    m.op     = (r.op == REQ_READ) ? MSG_DATA :
               (r.op == REQ_READ_EXCL) ? MSG_DATA_EXCL : MSG_ACK;
    exp_msgs.push_back(m);
    ref_dir[idx] = e;
endtask

`endif

// ==== dv/coh_dir_tb.sv ====
`timescale 1ns/1ps

module coh_dir_tb;
    import coh_dir_pkg::*;

    localparam int       num_reqs   = 300;
    localparam int       max_cycles = num_reqs * 40 + 1000;
    localparam int       pool_size  = 24;
    localparam node_id_t mc_node    = 8'h80;

    logic                  clk;
    logic                  reset_n;
    dir_req_t              req;
    logic                  req_valid;
    logic                  req_ready;
    logic                  ack_valid;
    node_id_t              ack_source;
    noc_msg_t              msg;
    logic                  msg_valid;
    logic                  msg_ready;
    logic [addr_width-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [stat_width-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    int                    value_errors;
    int                    other_errors;
    int                    cycles;
    int                    accepted;
    int                    stall_left;
    bit                    saw_full;
    bit                    held;
    noc_msg_t              held_msg;
    core_mask_t            inv_pend;
    core_mask_t            ack_wait;
    int                    ack_delay [num_cores];
    logic [addr_width-1:0] line_pool [pool_size];
    logic [stat_width-1:0] rd_val;
    logic [1:0]            rd_resp;

    `include "coh_dir_model.svh"

    coh_dir_top u_coh_dir_top (
        .clk        (clk),
        .reset_n    (reset_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .ack_valid  (ack_valid),
        .ack_source (ack_source),
        .msg        (msg),
        .msg_valid  (msg_valid),
        .msg_ready  (msg_ready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    always #5 clk = ~clk;

    task automatic flag_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        value_errors++;
    endtask

    task automatic flag_problem(input string what);
        $display("ERROR at %0t: %s", $time, what);
        other_errors++;
    endtask

    function automatic dir_req_t make_request();
        dir_req_t r;
        int       pick;
        pick     = $urandom_range(0, 99);
        r.addr   = line_pool[$urandom_range(0, pool_size - 1)] |
                   addr_width'($urandom_range(0, 63));
        r.source = node_id_t'($urandom_range(0, num_cores - 1));
        if (pick < 40) begin
            r.op = REQ_READ;
        end else if (pick < 60) begin
            r.op = REQ_READ_EXCL;
        end else if (pick < 80) begin
            r.op = REQ_WRITE;
        end else begin
            r.op = REQ_INVALIDATE;
        end
        // Occasional flush from the memory controller
        if (pick >= 95) begin
            r.source = mc_node;
        end
        return r;
    endfunction

    task automatic send_request(input dir_req_t r);
        req       <= r;
        req_valid <= 1'b1;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        req_valid <= 1'b0;
    endtask

    task automatic check_msg(input noc_msg_t m);
        noc_msg_t e;
        if (exp_msgs.size() == 0) begin
            flag_problem($sformatf("unexpected message op %0d to node 0x%0h", m.op, m.target));
        end else begin
            e = exp_msgs.pop_front();
            if (m.addr !== e.addr) begin
                flag_mismatch("msg.addr", e.addr, m.addr);
            end
            if (m.op !== e.op) begin
                flag_mismatch("msg.op", e.op, m.op);
            end
            if (m.target !== e.target) begin
                flag_mismatch("msg.target", e.target, m.target);
            end
        end
        if (m.op == MSG_INVALIDATE) begin
            inv_pend[m.target[1:0]]  = 1'b1;
            ack_wait[m.target[1:0]]  = 1'b1;
            ack_delay[m.target[1:0]] = $urandom_range(0, 5);
        end else if (inv_pend != '0) begin
            flag_problem("reply sent before every invalidated core acknowledged");
        end
    endtask

    task automatic read_stat(input logic [addr_width-1:0] addr,
                             output logic [stat_width-1:0] data, output logic [1:0] resp);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(posedge clk);
        while (!arready) begin
            @(posedge clk);
        end
        arvalid <= 1'b0;
        rready  <= 1'b1;
        @(posedge clk);
        if (!rvalid) begin
            flag_problem("rvalid did not rise one cycle after the AR transfer");
        end
        if (arready) begin
            flag_problem("arready high while a read is pending");
        end
        while (!rvalid) begin
            @(posedge clk);
        end
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic check_stat(input string name, input logic [addr_width-1:0] addr,
                              input logic [1:0] exp_resp, input int exp_val);
        read_stat(addr, rd_val, rd_resp);
        if (rd_resp !== exp_resp) begin
            flag_mismatch({name, " rresp"}, exp_resp, rd_resp);
        end
        if (rd_val !== stat_width'(exp_val)) begin
            flag_mismatch({name, " rdata"}, exp_val, rd_val);
        end
    endtask

    // Requests into the model, message checks and the core responders
    always @(posedge clk) begin : monitor
        bit sent;
        if (reset_n) begin
            if (req_valid && req_ready) begin
                apply_request(req);
                accepted++;
            end
            if (req_valid && !req_ready) begin
                saw_full = 1'b1;
            end
            if (held) begin
                if (!msg_valid) begin
                    flag_problem("msg_valid dropped before the message was taken");
                end else if (msg !== held_msg) begin
                    flag_mismatch("msg (held)", held_msg, msg);
                end
            end
            held     = msg_valid && !msg_ready;
            held_msg = msg;
            if (msg_valid && msg_ready) begin
                check_msg(msg);
            end
            if (ack_valid && !ack_source[7]) begin
                inv_pend[ack_source[1:0]] = 1'b0;
            end
            // One ack per cycle, lowest core first once its delay runs out
            sent = 1'b0;
            ack_valid <= 1'b0;
            for (int c = 0; c < num_cores; c++) begin
                if (ack_wait[c] && ack_delay[c] == 0 && !sent) begin
                    ack_valid   <= 1'b1;
                    ack_source  <= node_id_t'(c);
                    ack_wait[c] = 1'b0;
                    sent        = 1'b1;
                end else if (ack_wait[c] && ack_delay[c] > 0) begin
                    ack_delay[c]--;
                end
            end
            // Stray acks from the memory controller must be ignored
            if (!sent && $urandom_range(0, 19) == 0) begin
                ack_valid  <= 1'b1;
                ack_source <= mc_node;
            end
        end
    end

    // Random outbound stalls
    always @(posedge clk) begin
        if (stall_left > 0) begin
            stall_left--;
            msg_ready <= 1'b0;
        end else if ($urandom_range(0, 15) == 0) begin
            stall_left = $urandom_range(3, 14);
            msg_ready <= 1'b0;
        end else begin
            msg_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, %0d of %0d requests accepted, %0d messages owed",
                     cycles, accepted, num_reqs, exp_msgs.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(59667));
        clk          = 1'b0;
        reset_n      = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        ack_valid    = 1'b0;
        ack_source   = '0;
        msg_ready    = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        accepted     = 0;
        stall_left   = 0;
        saw_full     = 1'b0;
        held         = 1'b0;
        inv_pend     = '0;
        ack_wait     = '0;
        for (int c = 0; c < num_cores; c++) begin
            ack_delay[c] = 0;
        end
        // 24 lines over 16 sets, so sets 0 to 7 see two tags
        for (int k = 0; k < pool_size; k++) begin
            line_pool[k] = (addr_width'(k / 16 * 5 + 3) << (offset_bits + index_bits)) |
                           (addr_width'(k % 16) << offset_bits);
        end
        clear_model();
        repeat (2) @(posedge clk);
        if (msg_valid || req_ready || rvalid || arready) begin
            flag_problem("a valid or ready output was high during reset");
        end
        reset_n <= 1'b1;
        for (int i = 0; i < num_reqs; i++) begin
            send_request(make_request());
            if ($urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 4)) @(posedge clk);
            end
        end
        while (exp_msgs.size() != 0 || inv_pend != '0 || msg_valid) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (!saw_full) begin
            flag_problem("req_ready never dropped, queue was never seen full");
        end
        check_stat("hit count", stat_hit_addr, axi_resp_okay, exp_hits);
        check_stat("miss count", stat_miss_addr, axi_resp_okay, exp_misses);
        check_stat("evict count", stat_evict_addr, axi_resp_okay, exp_evicts);
        check_stat("unmapped read", 32'h0000_000C, axi_resp_slverr, 0);
        $display("Error counts: %0d value mismatches, %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
